// ==== Makefile ====
# Verilator build, run and lint for the host to core command bridge

VERILATOR  ?= verilator
TOP        ?= tb_hps_io
RTL_TOP    ?= hps_io_top
FILELIST   ?= src.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# the log decides pass or fail
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Test passed" $(LOG) || \
		(echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== conf_str_rom.sv ====
// byte wide rom holding the configuration string, one clock read latency
`timescale 1ns/1ps
`default_nettype none

`include "hps_io_config.svh"

module conf_str_rom (
	input  logic                    clk_sys,
	input  logic [`CONF_ADDR_W-1:0] addr,
	output logic [7:0]              rd_data
);

	localparam int LEN   = `CONF_STR_LEN;
	localparam int DEPTH = 1 << `CONF_ADDR_W;

	// string literal packs the first character at the top
	localparam logic [LEN*8-1:0] STR = `CONF_STR;

	logic [7:0] rom [DEPTH];

	// unused tail reads back as zero
	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			rom[i] = (i < LEN) ? STR[(LEN-i)*8-1 -: 8] : 8'h00;
		end
	end

	always_ff @(posedge clk_sys) begin
		rd_data <= rom[addr];
	end

endmodule

`default_nettype wire

// ==== fio_loader.sv ====
// file channel decoder that turns host data words into ioctl byte writes
`timescale 1ns/1ps
`default_nettype none

`include "hps_io_config.svh"

module fio_loader
	import hps_bus_pkg::*;
	import hps_core_pkg::*;
(
	input  logic        clk_sys,
	input  logic        rst_n,
	input  hps_word_t   word,
	output ioctl_t      ioctl,
	output logic [15:0] dout
);

	fio_op_e                  op;
	logic [`IOCTL_ADDR_W-1:0] addr_q;
	logic                     wr_q;

	assign op = fio_op_e'(word.opcode);

	// no read path on the file channel
	assign dout = '0;

	//////////////////////////////////////////////////////////////////////
	// download control
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			ioctl  <= '0;
			addr_q <= '0;
			wr_q   <= 1'b0;
		end else begin
			// address and byte settle a cycle before the write strobe
			ioctl.wr <= wr_q;
			wr_q     <= 1'b0;

			if (word.valid) begin
				case (op)
					FIO_FILE_INDEX: begin
						if (word.idx == `HPS_IDX_W'd1)
							ioctl.index <= word.data;
					end
					FIO_FILE_TX: begin
						case (word.idx)
							`HPS_IDX_W'd1: begin
								if (|word.data) begin
									ioctl.download <= 1'b1;
									addr_q         <= '0;
								end else begin
									ioctl.download <= 1'b0;
								end
							end
							// optional start address
							`HPS_IDX_W'd2: addr_q[15:0] <= word.data;
							`HPS_IDX_W'd3: begin
								addr_q[`IOCTL_ADDR_W-1:16] <=
									word.data[`IOCTL_ADDR_W-17:0];
							end
							default: ;
						endcase
					end
					FIO_FILE_TX_DAT: begin
						// stray data outside a download is dropped
						if (ioctl.download) begin
							ioctl.addr <= addr_q;
							ioctl.dout <= word.data[7:0];
							wr_q       <= 1'b1;
							addr_q     <= addr_q + 1'b1;
						end
					end
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== hps_bus_pkg.sv ====
// host side types for the command bridge bus, framed words and opcodes
`default_nettype none

`include "hps_io_config.svh"

package hps_bus_pkg;

	// host to core bus lines
	typedef struct packed {
		logic                   io_strobe;
		logic                   io_enable;
		logic                   fp_enable;
		logic [`HPS_WORD_W-1:0] io_din;
	} hps_bus_in_t;

	// core to host bus lines
	typedef struct packed {
		logic [`HPS_WORD_W-1:0] dout;
		logic                   ioctl_wait;
	} hps_bus_out_t;

	// one word of a frame as seen by a decoder
	typedef struct packed {
		logic                   valid;
		logic [`HPS_WORD_W-1:0] opcode;
		logic [`HPS_IDX_W-1:0]  idx;
		logic [`HPS_WORD_W-1:0] data;
		logic                   start;
		logic                   done;
	} hps_word_t;

	typedef enum logic [15:0] {
		UIO_CFG        = 16'h0001,
		UIO_JOY0       = 16'h0002,
		UIO_JOY1       = 16'h0003,
		UIO_CONF_STR   = 16'h0014,
		UIO_STATUS     = 16'h001E,
		UIO_STATUS_REQ = 16'h0029
	} uio_op_e;

	typedef enum logic [15:0] {
		FIO_FILE_TX     = 16'h0053,
		FIO_FILE_TX_DAT = 16'h0054,
		FIO_FILE_INDEX  = 16'h0055
	} fio_op_e;

endpackage

`default_nettype wire

// ==== hps_core_pkg.sv ====
// core side types for the download port and the configuration word
`default_nettype none

`include "hps_io_config.svh"

package hps_core_pkg;

	// download port toward core memory, one byte per write
	typedef struct packed {
		logic                    download;
		logic                    wr;
		logic [`IOCTL_ADDR_W-1:0] addr;
		logic [7:0]              dout;
		logic [15:0]             index;
	} ioctl_t;

	// configuration word from the host, msb first
	typedef struct packed {
		logic [4:0] rsvd_15_11;
		logic       direct_video;
		logic [4:0] rsvd_9_5;
		// line doubler forced on for vga monitors
		logic       forced_scandoubler;
		// vga scaler and csync live here, handled outside the core
		logic [1:0] rsvd_3_2;
		logic [1:0] buttons;
	} cfg_word_t;

endpackage

`default_nettype wire

// ==== hps_io_config.svh ====
// host command bridge widths and the core configuration string
`ifndef HPS_IO_CONFIG_SVH
`define HPS_IO_CONFIG_SVH

// host bus word
`define HPS_WORD_W 16

// argument index within one command frame, saturates at all ones
`define HPS_IDX_W 6

// download address into core memory
`define IOCTL_ADDR_W 27

// menu string handed to the host, first character at rom address 0
`define CONF_STR "RETRO;;O12,Scale,1x,2x,3x;T0,Reset;V,v1.00"
`define CONF_STR_LEN 42

// rom address width, one spare code past the last byte
`define CONF_ADDR_W $clog2(`CONF_STR_LEN + 1)

`endif

// ==== hps_io_top.sv ====
// host to core command bridge with user-io and file channels
`timescale 1ns/1ps
`default_nettype none

module hps_io_top
	import hps_bus_pkg::*;
	import hps_core_pkg::*;
(
	input  logic         clk_sys,
	input  logic         rst_n,
	input  hps_bus_in_t  bus_in,
	input  logic [63:0]  status_in,
	input  logic         status_set,
	input  logic         ioctl_wait,
	output hps_bus_out_t bus_out,
	output logic [31:0]  joystick_0,
	output logic [31:0]  joystick_1,
	output logic [63:0]  status,
	output logic [1:0]   buttons,
	output logic         forced_scandoubler,
	output logic         direct_video,
	output ioctl_t       ioctl
);

	hps_word_t   uio_word;
	hps_word_t   fio_word;
	cfg_word_t   cfg;
	logic [15:0] uio_dout;
	logic [15:0] fio_dout;

	hps_word_framer u_uio_framer (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.enable  (bus_in.io_enable),
		.bus     (bus_in),
		.word    (uio_word)
	);

	hps_word_framer u_fio_framer (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.enable  (bus_in.fp_enable),
		.bus     (bus_in),
		.word    (fio_word)
	);

	uio_regs u_uio_regs (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.word       (uio_word),
		.status_in  (status_in),
		.status_set (status_set),
		.cfg        (cfg),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.status     (status),
		.dout       (uio_dout)
	);

	fio_loader u_fio_loader (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.word    (fio_word),
		.ioctl   (ioctl),
		.dout    (fio_dout)
	);

	// file channel owns the reply while its enable is up
	assign bus_out.dout       = bus_in.fp_enable ? fio_dout : uio_dout;
	assign bus_out.ioctl_wait = ioctl_wait;

	assign buttons            = cfg.buttons;
	assign forced_scandoubler = cfg.forced_scandoubler;
	assign direct_video       = cfg.direct_video;

endmodule

`default_nettype wire

// ==== hps_word_framer.sv ====
// splits one channel of the host bus into opcode and numbered argument words
`timescale 1ns/1ps
`default_nettype none

`include "hps_io_config.svh"

module hps_word_framer
	import hps_bus_pkg::*;
(
	input  logic        clk_sys,
	input  logic        rst_n,
	input  logic        enable,
	input  hps_bus_in_t bus,
	output hps_word_t   word
);

	logic                   enable_d;
	logic                   has_op;
	logic                   valid_q;
	logic                   start_q;
	logic                   done_q;
	logic [`HPS_WORD_W-1:0] opcode_q;
	logic [`HPS_IDX_W-1:0]  idx_q;
	logic [`HPS_WORD_W-1:0] data_q;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			enable_d <= 1'b0;
			has_op   <= 1'b0;
			valid_q  <= 1'b0;
			start_q  <= 1'b0;
			done_q   <= 1'b0;
			opcode_q <= '0;
			idx_q    <= '0;
		end else begin
			enable_d <= enable;
			valid_q  <= 1'b0;
			start_q  <= 1'b0;
			// one pulse at the end of a frame
			done_q   <= enable_d & ~enable;
			if (!enable) begin
				has_op <= 1'b0;
				idx_q  <= '0;
			end else if (bus.io_strobe) begin
				if (!has_op) begin
					// first word of the frame
					has_op   <= 1'b1;
					opcode_q <= bus.io_din;
					start_q  <= 1'b1;
					idx_q    <= '0;
				end else begin
					valid_q <= 1'b1;
					if (idx_q != '1)
						idx_q <= idx_q + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (enable && bus.io_strobe)
			data_q <= bus.io_din;
	end

	assign word.valid  = valid_q;
	assign word.opcode = opcode_q;
	assign word.idx    = idx_q;
	assign word.data   = data_q;
	assign word.start  = start_q;
	assign word.done   = done_q;

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+.
hps_bus_pkg.sv
hps_core_pkg.sv
conf_str_rom.sv
hps_word_framer.sv
uio_regs.sv
fio_loader.sv
hps_io_top.sv
tb_hps_io.sv

// ==== tb_hps_io.sv ====
// testbench for the host to core command bridge with frames on both channels
`timescale 1ns/1ps
`default_nettype none

`include "hps_io_config.svh"

module tb_hps_io
	import hps_bus_pkg::*;
	import hps_core_pkg::*;
();

	localparam int LEN         = `CONF_STR_LEN;
	localparam int DATA_BYTES  = 24;
	localparam int MAX_ARGS    = LEN + 2;
	// longest frame is enable, opcode and args with idle gaps plus the tail
	localparam int MAX_FRAME   = 2 * MAX_ARGS + 8;
	localparam int NUM_FRAMES  = 16;
	localparam int CYCLE_LIMIT = NUM_FRAMES * MAX_FRAME;

	localparam logic [LEN*8-1:0] CONF = `CONF_STR;

	typedef struct packed {
		logic [`IOCTL_ADDR_W-1:0] addr;
		logic [7:0]               data;
	} wr_entry_t;

	logic         clk_sys;
	logic         rst_n;
	hps_bus_in_t  bus_in;
	logic [63:0]  status_in;
	logic         status_set;
	logic         ioctl_wait;
	hps_bus_out_t bus_out;
	logic [31:0]  joystick_0;
	logic [31:0]  joystick_1;
	logic [63:0]  status;
	logic [1:0]   buttons;
	logic         forced_scandoubler;
	logic         direct_video;
	ioctl_t       ioctl;

	// reference model state
	logic [3:0]   m_req_cnt;
	logic [63:0]  m_req;
	logic [15:0]  m_index;
	wr_entry_t    exp_wr[$];

	logic [31:0]  lfsr_state;
	logic [15:0]  args    [0:MAX_ARGS];
	logic [15:0]  replies [0:MAX_ARGS];
	int           value_errs = 0;
	int           write_errs = 0;
	int           other_errs = 0;
	int           cycles = 0;

	hps_io_top hps_io_top_i (
		.clk_sys            (clk_sys),
		.rst_n              (rst_n),
		.bus_in             (bus_in),
		.status_in          (status_in),
		.status_set         (status_set),
		.ioctl_wait         (ioctl_wait),
		.bus_out            (bus_out),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.ioctl              (ioctl)
	);

	always #4 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run still going after %0d cycles", cycles);
			$display("Test failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////////////////////////

	// galois lfsr stepped once per bit taken
	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			if (lfsr_state[0])
				lfsr_state = (lfsr_state >> 1) ^ 32'hA3000000;
			else
				lfsr_state = lfsr_state >> 1;
			r = {r[62:0], lfsr_state[0]};
		end
		return r;
	endfunction

	// reply read at strobe s answers word s-1
	// word 0 is the opcode
	function automatic logic [15:0] ref_reply(input logic [15:0] opcode, input int s);
		logic [15:0] r;
		int          c;
		r = 16'h0000;
		c = s - 2;
		if (opcode == UIO_STATUS_REQ) begin
			if (s == 1)
				r = {8'hA0, 4'h0, m_req_cnt};
			else if (s >= 2 && s <= 4)
				r = m_req[c*16 +: 16];
		end else if (opcode == UIO_CONF_STR) begin
			if (s >= 2 && s <= LEN + 1)
				r = {8'h00, 8'(CONF >> ((LEN - 1 - c) * 8))};
		end
		return r;
	endfunction

	task automatic check_val(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		assert (got === exp) else begin
			value_errs++;
			$display("** Error: %s = %h, expected %h", name, got, exp);
		end
	endtask

	// enable, opcode and then n args from args[] with one idle cycle between strobes
	task automatic send_frame(input logic file_ch, input logic [15:0] opcode, input int n);
		@(negedge clk_sys);
		if (file_ch)
			bus_in.fp_enable = 1'b1;
		else
			bus_in.io_enable = 1'b1;
		for (int k = 0; k <= n; k++) begin
			@(negedge clk_sys);
			while (ioctl_wait) begin
				@(negedge clk_sys);
			end
			replies[k]       = bus_out.dout;
			bus_in.io_strobe = 1'b1;
			bus_in.io_din    = (k == 0) ? opcode : args[k];
			@(negedge clk_sys);
			bus_in.io_strobe = 1'b0;
		end
		@(negedge clk_sys);
		bus_in.io_enable = 1'b0;
		bus_in.fp_enable = 1'b0;
		repeat (3) @(negedge clk_sys);
	endtask

	task automatic check_replies(input logic [15:0] opcode, input int n);
		for (int s = 1; s <= n; s++) begin
			check_val($sformatf("dout at strobe %0d", s), 64'(replies[s]),
				64'(ref_reply(opcode, s)));
		end
	endtask

	task automatic pulse_status_set(input logic [63:0] val);
		@(negedge clk_sys);
		status_in  = val;
		status_set = 1'b1;
		@(negedge clk_sys);
		status_set = 1'b0;
		m_req_cnt  = m_req_cnt + 4'd1;
		m_req      = val;
	endtask

	//////////////////////////////////////////////////////////////////////
	// core side back-pressure
	//////////////////////////////////////////////////////////////////////

	// memory busy for one cycle after every download write
	always @(negedge clk_sys) begin
		assert (bus_out.ioctl_wait === ioctl_wait) else begin
			value_errs++;
			$display("** Error: bus_out.ioctl_wait = %h, expected %h",
				bus_out.ioctl_wait, ioctl_wait);
		end
		ioctl_wait <= rst_n && ioctl.wr;
	end

	//////////////////////////////////////////////////////////////////////
	// ioctl write checker
	//////////////////////////////////////////////////////////////////////

	always @(negedge clk_sys) begin
		wr_entry_t e;
		if (rst_n && ioctl.wr) begin
			assert (exp_wr.size() != 0) else begin
				write_errs++;
				$display("ioctl write at address %h when no write was expected",
					ioctl.addr);
			end
			if (exp_wr.size() != 0) begin
				e = exp_wr.pop_front();
				assert (ioctl.addr === e.addr) else begin
					write_errs++;
					$display("** Error: ioctl.addr = %h, expected %h", ioctl.addr, e.addr);
				end
				assert (ioctl.dout === e.data) else begin
					write_errs++;
					$display("** Error: ioctl.dout = %h, expected %h", ioctl.dout, e.data);
				end
				assert (ioctl.index === m_index) else begin
					write_errs++;
					$display("** Error: ioctl.index = %h, expected %h", ioctl.index, m_index);
				end
				assert (ioctl.download === 1'b1) else begin
					write_errs++;
					$display("** Error: ioctl.download = %h, expected 1", ioctl.download);
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////

	initial begin
		logic [26:0] start_addr;
		wr_entry_t   e;
		clk_sys    = 1'b0;
		rst_n      = 1'b0;
		bus_in     = '0;
		status_in  = '0;
		status_set = 1'b0;
		ioctl_wait = 1'b0;
		lfsr_state = 32'h7fa2;
		m_req_cnt  = 4'h0;
		m_req      = '0;
		m_index    = '0;
		repeat (4) @(negedge clk_sys);
		rst_n = 1'b1;
		@(negedge clk_sys);

		// everything idle after reset
		check_val("joystick_0", 64'(joystick_0), 64'h0);
		check_val("joystick_1", 64'(joystick_1), 64'h0);
		check_val("status", status, 64'h0);
		check_val("buttons", 64'(buttons), 64'h0);
		check_val("forced_scandoubler", 64'(forced_scandoubler), 64'h0);
		check_val("direct_video", 64'(direct_video), 64'h0);
		check_val("ioctl", 64'(ioctl), 64'h0);
		check_val("dout", 64'(bus_out.dout), 64'h0);

		// stray data before any download
		for (int i = 1; i <= 4; i++)
			args[i] = 16'(rand_bits(16));
		send_frame(1'b1, FIO_FILE_TX_DAT, 4);

		args[1] = 16'(rand_bits(16));
		send_frame(1'b0, UIO_CFG, 1);
		check_val("buttons", 64'(buttons), 64'(args[1][1:0]));
		check_val("forced_scandoubler", 64'(forced_scandoubler), 64'(args[1][4]));
		check_val("direct_video", 64'(direct_video), 64'(args[1][10]));

		args[1] = 16'(rand_bits(16));
		args[2] = 16'(rand_bits(16));
		send_frame(1'b0, UIO_JOY0, 2);
		check_val("joystick_0", 64'(joystick_0), 64'({args[2], args[1]}));
		args[1] = 16'(rand_bits(16));
		args[2] = 16'(rand_bits(16));
		send_frame(1'b0, UIO_JOY1, 2);
		check_val("joystick_1", 64'(joystick_1), 64'({args[2], args[1]}));

		for (int i = 1; i <= 4; i++)
			args[i] = 16'(rand_bits(16));
		send_frame(1'b0, UIO_STATUS, 4);
		check_val("status", status, {args[4], args[3], args[2], args[1]});

		// request counter before and after its wrap at 16
		for (int i = 0; i < 3; i++)
			pulse_status_set(rand_bits(64));
		send_frame(1'b0, UIO_STATUS_REQ, 4);
		check_replies(UIO_STATUS_REQ, 4);
		for (int i = 0; i < 14; i++)
			pulse_status_set(rand_bits(64));
		send_frame(1'b0, UIO_STATUS_REQ, 4);
		check_replies(UIO_STATUS_REQ, 4);

		for (int i = 1; i <= LEN + 2; i++)
			args[i] = 16'(rand_bits(16));
		send_frame(1'b0, UIO_CONF_STR, LEN + 2);
		check_replies(UIO_CONF_STR, LEN + 2);

		// download of random bytes from a random start address
		m_index = 16'(rand_bits(16));
		args[1] = m_index;
		send_frame(1'b1, FIO_FILE_INDEX, 1);
		start_addr = 27'(rand_bits(27));
		args[1] = 16'(rand_bits(16)) | 16'h0001;
		args[2] = start_addr[15:0];
		args[3] = {5'b0, start_addr[26:16]};
		send_frame(1'b1, FIO_FILE_TX, 3);
		check_val("ioctl.download", 64'(ioctl.download), 64'h1);
		check_val("ioctl.index", 64'(ioctl.index), 64'(m_index));
		for (int i = 0; i < DATA_BYTES; i++) begin
			args[i+1] = 16'(rand_bits(16));
			e.addr    = start_addr + 27'(i);
			e.data    = args[i+1][7:0];
			exp_wr.push_back(e);
		end
		send_frame(1'b1, FIO_FILE_TX_DAT, DATA_BYTES);
		args[1] = 16'h0000;
		send_frame(1'b1, FIO_FILE_TX, 1);
		check_val("ioctl.download", 64'(ioctl.download), 64'h0);

		// data after the end frame goes nowhere
		for (int i = 1; i <= 4; i++)
			args[i] = 16'(rand_bits(16));
		send_frame(1'b1, FIO_FILE_TX_DAT, 4);

		assert (exp_wr.size() == 0) else begin
			other_errs++;
			$display("%0d expected ioctl writes never happened", exp_wr.size());
		end
		$display("errors: value %0d, ioctl write %0d, other %0d",
			value_errs, write_errs, other_errs);
		if (value_errs + write_errs + other_errs == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== uio_regs.sv ====
// user-io command decoder with config, joystick and status registers and replies
`timescale 1ns/1ps
`default_nettype none

`include "hps_io_config.svh"

module uio_regs
	import hps_bus_pkg::*;
	import hps_core_pkg::*;
(
	input  logic        clk_sys,
	input  logic        rst_n,
	input  hps_word_t   word,
	input  logic [63:0] status_in,
	input  logic        status_set,
	output cfg_word_t   cfg,
	output logic [31:0] joystick_0,
	output logic [31:0] joystick_1,
	output logic [63:0] status,
	output logic [15:0] dout
);

	localparam int ROM_AW = `CONF_ADDR_W;

	uio_op_e             op;
	logic [ROM_AW-1:0]   rom_addr;
	logic [7:0]          rom_data;
	logic                status_set_d;
	logic [3:0]          req_cnt;
	logic [63:0]         status_req;

	assign op = uio_op_e'(word.opcode);

	// index still holds the previous argument between strobes,
	// so the next byte is already waiting at the rom output
	assign rom_addr = ROM_AW'(word.idx);

	conf_str_rom u_conf_str_rom (
		.clk_sys (clk_sys),
		.addr    (rom_addr),
		.rd_data (rom_data)
	);

	//////////////////////////////////////////////////////////////////////
	// registers and reply word
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cfg          <= '0;
			joystick_0   <= '0;
			joystick_1   <= '0;
			status       <= '0;
			dout         <= '0;
			status_set_d <= 1'b0;
			req_cnt      <= '0;
			status_req   <= '0;
		end else begin
			// core asks the host to pick up a new status
			status_set_d <= status_set;
			if (status_set && !status_set_d) begin
				req_cnt    <= req_cnt + 1'b1;
				status_req <= status_in;
			end

			if (word.done) begin
				dout <= '0;
			end else if (word.start) begin
				if (op == UIO_STATUS_REQ)
					dout <= {8'hA0, 4'h0, req_cnt};
				else
					dout <= '0;
			end else if (word.valid) begin
				dout <= '0;
				case (op)
					UIO_CFG: begin
						if (word.idx == `HPS_IDX_W'd1)
							cfg <= cfg_word_t'(word.data);
					end
					UIO_JOY0: begin
						if (word.idx == `HPS_IDX_W'd1)
							joystick_0[15:0] <= word.data;
						else if (word.idx == `HPS_IDX_W'd2)
							joystick_0[31:16] <= word.data;
					end
					UIO_JOY1: begin
						if (word.idx == `HPS_IDX_W'd1)
							joystick_1[15:0] <= word.data;
						else if (word.idx == `HPS_IDX_W'd2)
							joystick_1[31:16] <= word.data;
					end
					// low half-word first
					UIO_STATUS: begin
						case (word.idx)
							`HPS_IDX_W'd1: status[15:0]  <= word.data;
							`HPS_IDX_W'd2: status[31:16] <= word.data;
							`HPS_IDX_W'd3: status[47:32] <= word.data;
							`HPS_IDX_W'd4: status[63:48] <= word.data;
							default: ;
						endcase
					end
					// half-word 3 would only show after the frame ends
					UIO_STATUS_REQ: begin
						case (word.idx)
							`HPS_IDX_W'd1: dout <= status_req[15:0];
							`HPS_IDX_W'd2: dout <= status_req[31:16];
							`HPS_IDX_W'd3: dout <= status_req[47:32];
							default: ;
						endcase
					end
					UIO_CONF_STR: begin
						if (int'(word.idx) <= `CONF_STR_LEN)
							dout <= {8'h00, rom_data};
					end
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire
